/* hw/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// instruction word width.
`define RV_ILEN 32

// one compressed parcel.
`define RV_PLEN 16

// fetch address width.
`define FETCH_PC_W 32

// parcels held by the aligner.
`define FETCH_BUF_PARCELS 3

`endif

/* hw/rv_isa_pkg.sv */
`include "rv_consts.svh"

package rv_isa_pkg;

    typedef logic [`RV_ILEN-1:0] inst_t;
    typedef logic [`RV_PLEN-1:0] parcel_t;
    typedef logic [4:0]          reg_idx_t;
    typedef logic [6:0]          opcode_t;
    typedef logic [2:0]          funct3_t;
    typedef logic [6:0]          funct7_t;

    // major opcodes.
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LUI    = 7'b0110111;

    // alu function codes.
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // funct7 selects sub and sra.
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

    localparam reg_idx_t REG_X0 = 5'd0;
    // stack pointer, c.lui with x2 is c.addi16sp.
    localparam reg_idx_t REG_SP = 5'd2;

endpackage

/* hw/fetch_pkg.sv */
`include "rv_consts.svh"

package fetch_pkg;

    // byte address of a fetched instruction.
    typedef logic [`FETCH_PC_W-1:0] pc_t;

    // valid parcels in the aligner buffer.
    typedef logic [$clog2(`FETCH_BUF_PARCELS+1)-1:0] pcount_t;

endpackage

/* hw/parcel_aligner.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module parcel_aligner
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_word_valid,
    input  rv_isa_pkg::inst_t i_word,
    output logic              o_hold,
    output logic              o_raw_valid,
    output rv_isa_pkg::inst_t o_raw,
    output fetch_pkg::pc_t    o_raw_pc
);
    import rv_isa_pkg::*;
    import fetch_pkg::*;

    // index 0 is the oldest parcel.
    parcel_t [`FETCH_BUF_PARCELS-1:0] buf_q;
    parcel_t [`FETCH_BUF_PARCELS-1:0] buf_n;

    pcount_t count_q;
    pcount_t count_n;
    pcount_t take;
    pcount_t remain;

    pc_t  pc_q;
    pc_t  pc_step;

    logic accept;
    logic emit16;
    logic emit32;
    logic emit;

    // two parcels buffered means no room for another word.
    assign o_hold = (count_q >= 2'd2);
    assign accept = i_word_valid && !o_hold;

    assign emit16 = (count_q != 2'd0) && (buf_q[0][1:0] != 2'b11);
    assign emit32 = (count_q >= 2'd2) && (buf_q[0][1:0] == 2'b11);
    assign emit   = emit16 || emit32;

    assign pc_step = emit32 ? pc_t'(4) : pc_t'(2);

    always_comb
    begin
        take   = emit32 ? 2'd2 : (emit16 ? 2'd1 : 2'd0);
        remain = count_q - take;

        // drop the consumed parcels.
        buf_n = buf_q >> (take * `RV_PLEN);

        // new word lands right after what is left.
        if (accept)
        begin
            case (remain)
                2'd0:
                    buf_n[1:0] = i_word;
                default:
                    buf_n[2:1] = i_word;
            endcase
        end

        count_n = remain + (accept ? 2'd2 : 2'd0);
    end

    always_ff @(posedge i_clk)
    begin
        buf_q <= buf_n;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            count_q     <= '0;
            pc_q        <= '0;
            o_raw_valid <= 1'b0;
        end
        else
        begin
            count_q     <= count_n;
            o_raw_valid <= emit;
            if (emit)
            begin
                pc_q <= pc_q + pc_step;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (emit)
        begin
            o_raw_pc <= pc_q;
            if (emit32)
            begin
                o_raw <= {buf_q[1], buf_q[0]};
            end
            else
            begin
                // 16-bit form, upper half zero.
                o_raw <= {{(`RV_ILEN-`RV_PLEN){1'b0}}, buf_q[0]};
            end
        end
    end

endmodule

/* hw/c_expander.sv */
`timescale 1ns/1ps

module c_expander
(
    input  rv_isa_pkg::inst_t i_inst,
    output rv_isa_pkg::inst_t o_inst,
    output logic              o_compressed,
    output logic              o_illegal
);
    import rv_isa_pkg::*;

    reg_idx_t    rd;
    reg_idx_t    rs2;
    // rd' and rs2' map to x8..x15.
    reg_idx_t    rd_p;
    reg_idx_t    rs2_p;
    logic [2:0]  c_funct3;
    logic [11:0] imm12;
    logic [4:0]  shamt;
    logic        imm_zero;

    assign rd       = i_inst[11:7];
    assign rs2      = i_inst[6:2];
    assign rd_p     = {2'b01, i_inst[9:7]};
    assign rs2_p    = {2'b01, i_inst[4:2]};
    assign c_funct3 = i_inst[15:13];
    assign shamt    = i_inst[6:2];
    assign imm_zero = ({i_inst[12], i_inst[6:2]} == 6'd0);

    // 6-bit immediate, sign extended.
    assign imm12 = {{6{i_inst[12]}}, i_inst[12], i_inst[6:2]};

    assign o_compressed = (i_inst[1:0] != 2'b11);

    always_comb
    begin
        o_inst    = i_inst;
        o_illegal = o_compressed;

        case (i_inst[1:0])
            2'b01:
            begin
                case (c_funct3)
                    3'b000:
                    begin
                        // c.addi.
                        o_inst    = {imm12, rd, F3_ADD_SUB, rd, OPC_OP_IMM};
                        o_illegal = 1'b0;
                    end

                    3'b010:
                    begin
                        // c.li.
                        o_inst    = {imm12, REG_X0, F3_ADD_SUB, rd, OPC_OP_IMM};
                        o_illegal = 1'b0;
                    end

                    3'b011:
                    begin
                        // c.lui, rd of x0 or x2 and zero imm are reserved.
                        if (rd != REG_X0 && rd != REG_SP && !imm_zero)
                        begin
                            o_inst    = {{14{i_inst[12]}}, imm12[5:0], rd, OPC_LUI};
                            o_illegal = 1'b0;
                        end
                    end

                    3'b100:
                    begin
                        case (i_inst[11:10])
                            2'b00:
                            begin
                                if (!i_inst[12])
                                begin
                                    o_inst = {F7_BASE, shamt, rd_p, F3_SRL_SRA, rd_p,
                                              OPC_OP_IMM};
                                    o_illegal = 1'b0;
                                end
                            end

                            2'b01:
                            begin
                                if (!i_inst[12])
                                begin
                                    o_inst = {F7_ALT, shamt, rd_p, F3_SRL_SRA, rd_p,
                                              OPC_OP_IMM};
                                    o_illegal = 1'b0;
                                end
                            end

                            2'b10:
                            begin
                                // c.andi.
                                o_inst    = {imm12, rd_p, F3_AND, rd_p, OPC_OP_IMM};
                                o_illegal = 1'b0;
                            end

                            2'b11:
                            begin
                                // bit 12 set is the rv64 word group.
                                if (!i_inst[12])
                                begin
                                    o_illegal = 1'b0;
                                    case (i_inst[6:5])
                                        2'b00:
                                            o_inst = {F7_ALT, rs2_p, rd_p, F3_ADD_SUB,
                                                      rd_p, OPC_OP};
                                        2'b01:
                                            o_inst = {F7_BASE, rs2_p, rd_p, F3_XOR,
                                                      rd_p, OPC_OP};
                                        2'b10:
                                            o_inst = {F7_BASE, rs2_p, rd_p, F3_OR,
                                                      rd_p, OPC_OP};
                                        default:
                                            o_inst = {F7_BASE, rs2_p, rd_p, F3_AND,
                                                      rd_p, OPC_OP};
                                    endcase
                                end
                            end
                        endcase
                    end
                endcase
            end

            2'b10:
            begin
                case (c_funct3)
                    3'b000:
                    begin
                        // c.slli.
                        if (!i_inst[12])
                        begin
                            o_inst    = {F7_BASE, shamt, rd, F3_SLL, rd, OPC_OP_IMM};
                            o_illegal = 1'b0;
                        end
                    end

                    3'b100:
                    begin
                        // rs2 of x0 is jr, jalr or ebreak.
                        if (rs2 != REG_X0)
                        begin
                            o_illegal = 1'b0;
                            if (!i_inst[12])
                            begin
                                o_inst = {F7_BASE, rs2, REG_X0, F3_ADD_SUB, rd, OPC_OP};
                            end
                            else
                            begin
                                o_inst = {F7_BASE, rs2, rd, F3_ADD_SUB, rd, OPC_OP};
                            end
                        end
                    end
                endcase
            end
        endcase
    end

endmodule

/* hw/fetch_frontend.sv */
`timescale 1ns/1ps

module fetch_frontend
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_word_valid,
    input  rv_isa_pkg::inst_t i_word,
    output logic              o_hold,
    output logic              o_inst_valid,
    output rv_isa_pkg::inst_t o_inst,
    output fetch_pkg::pc_t    o_pc,
    output logic              o_compressed,
    output logic              o_illegal
);
    import rv_isa_pkg::*;

    // raw instruction before expansion.
    inst_t raw;

    parcel_aligner u_aligner
    (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_word_valid (i_word_valid),
        .i_word       (i_word),
        .o_hold       (o_hold),
        .o_raw_valid  (o_inst_valid),
        .o_raw        (raw),
        .o_raw_pc     (o_pc)
    );

    // same cycle as the aligner output.
    c_expander u_expander
    (
        .i_inst       (raw),
        .o_inst       (o_inst),
        .o_compressed (o_compressed),
        .o_illegal    (o_illegal)
    );

endmodule

/* tb/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_word_valid,
    input  logic [31:0] i_word,
    input  logic        i_hold,
    input  logic        i_inst_valid,
    input  logic [31:0] i_inst,
    input  logic [31:0] i_pc,
    input  logic        i_compressed,
    input  logic        i_illegal,
    input  logic        i_finish,
    input  int          i_prog_len,
    output int          o_value_errors,
    output int          o_stream_errors,
    output int          o_checked,
    output logic        o_done
);

    localparam logic [6:0] OPC_IMM = 7'b0010011;

    logic [15:0] queue [$];
    logic [31:0] exp_pc;

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    // returns {illegal, expanded instruction}.
    function automatic logic [32:0] ref_expand(logic [15:0] p);
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [4:0]  rdp;
        logic [4:0]  rs2p;
        logic [5:0]  imm6;
        logic [11:0] simm;
        logic [2:0]  f3_alu;
        logic [31:0] inst;
        logic        bad;
        rd   = p[11:7];
        rs2  = p[6:2];
        rdp  = 5'd8 + {2'b00, p[9:7]};
        rs2p = 5'd8 + {2'b00, p[4:2]};
        imm6 = {p[12], p[6:2]};
        simm = {{6{imm6[5]}}, imm6};
        // sub, xor, or, and.
        f3_alu = (p[6:5] == 2'b00) ? 3'b000 : {1'b1, p[6], p[6] & p[5]};
        inst = '0;
        bad  = 1'b0;
        case ({p[1:0], p[15:13]})
            5'b01_000: inst = enc_i(simm, rd, 3'b000, rd, OPC_IMM);
            5'b01_010: inst = enc_i(simm, 5'd0, 3'b000, rd, OPC_IMM);
            5'b01_011:
                if (rd != 5'd0 && rd != 5'd2 && imm6 != 6'd0)
                    inst = {{14{imm6[5]}}, imm6, rd, 7'b0110111};
                else
                    bad = 1'b1;
            5'b01_100:
                if (p[11:10] == 2'b10)
                    inst = enc_i(simm, rdp, 3'b111, rdp, OPC_IMM);
                else if (p[12])
                    bad = 1'b1;
                else if (p[11])
                    inst = enc_r({1'b0, p[6:5] == 2'b00, 5'b0}, rs2p, rdp, f3_alu, rdp);
                else
                    inst = enc_i({1'b0, p[10], 5'b0, p[6:2]}, rdp, 3'b101, rdp, OPC_IMM);
            5'b10_000:
                if (p[12])
                    bad = 1'b1;
                else
                    inst = enc_i({7'b0, p[6:2]}, rd, 3'b001, rd, OPC_IMM);
            5'b10_100:
                if (rs2 == 5'd0)
                    bad = 1'b1;
                else
                    inst = enc_r(7'b0, rs2, p[12] ? rd : 5'd0, 3'b000, rd);
            default: bad = 1'b1;
        endcase
        if (bad)
            inst = {16'h0000, p};
        return {bad, inst};
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected)
        begin
            o_value_errors = o_value_errors + 1;
            $display("Error: %s of instruction %0d: expected %h, actual %h",
                     name, o_checked, expected, actual);
        end
    endtask

    task automatic check_one();
        logic [15:0] lo;
        logic [32:0] model;
        logic [31:0] exp_inst;
        logic        exp_comp;
        if (queue.size() == 0)
        begin
            o_stream_errors = o_stream_errors + 1;
            $display("extra instruction at pc %h with no parcels left in the stream", i_pc);
        end
        else
        begin
            lo       = queue.pop_front();
            exp_comp = (lo[1:0] != 2'b11);
            model    = ref_expand(lo);
            if (!exp_comp && queue.size() == 0)
            begin
                o_stream_errors = o_stream_errors + 1;
                $display("32-bit instruction at pc %h came out before its upper half", i_pc);
            end
            else
            begin
                // 32-bit forms are never illegal.
                exp_inst = exp_comp ? model[31:0] : {queue.pop_front(), lo};
                check_value("pc", exp_pc, i_pc);
                check_value("inst", exp_inst, i_inst);
                check_value("compressed", {31'b0, exp_comp}, {31'b0, i_compressed});
                check_value("illegal", {31'b0, exp_comp & model[32]}, {31'b0, i_illegal});
                exp_pc    = exp_pc + (exp_comp ? 32'd2 : 32'd4);
                o_checked = o_checked + 1;
            end
        end
    endtask

    always @(posedge i_clk)
    begin
        if (i_rst)
        begin
            queue.delete();
            exp_pc          = '0;
            o_value_errors  = 0;
            o_stream_errors = 0;
            o_checked       = 0;
            o_done          = 1'b0;
        end
        else
        begin
            if (i_inst_valid)
                check_one();
            // after the pop the queue holds what the aligner buffers.
            check_value("hold", {31'b0, queue.size() >= 2}, {31'b0, i_hold});
            // the aligner takes a word only when not holding.
            if (i_word_valid && !i_hold)
            begin
                queue.push_back(i_word[15:0]);
                queue.push_back(i_word[31:16]);
            end
            if (i_finish && !o_done)
            begin
                if (queue.size() != 0)
                begin
                    o_stream_errors = o_stream_errors + 1;
                    $display("%0d parcels were accepted but never came out", queue.size());
                end
                if (o_checked != i_prog_len)
                begin
                    o_stream_errors = o_stream_errors + 1;
                    $display("expected %0d instructions but %0d came out",
                             i_prog_len, o_checked);
                end
                o_done = 1'b1;
            end
        end
    end

endmodule

/* tb/tb_frontend.sv */
`timescale 1ns/1ps

module tb_frontend;

    localparam int PROG_LEN   = 300;
    localparam int CLK_PERIOD = 10;
    // four cycles per instruction covers hold and random gaps.
    localparam int TIMEOUT_NS = PROG_LEN * 4 * CLK_PERIOD + 2000;

    logic        clk        = 1'b0;
    logic        rst        = 1'b1;
    logic        word_valid = 1'b0;
    logic [31:0] word       = '0;
    logic        hold;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        compressed;
    logic        illegal;

    logic        finish = 1'b0;
    logic        report_done;
    int          value_errors;
    int          stream_errors;
    int          checked;

    integer      seed = 5;
    int          n_inst;
    int          word_idx;
    logic [15:0] parcels [$];
    logic [31:0] words [$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    fetch_frontend uut
    (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_word_valid (word_valid),
        .i_word       (word),
        .o_hold       (hold),
        .o_inst_valid (inst_valid),
        .o_inst       (inst),
        .o_pc         (pc),
        .o_compressed (compressed),
        .o_illegal    (illegal)
    );

    tb_checker u_checker
    (
        .i_clk           (clk),
        .i_rst           (rst),
        .i_word_valid    (word_valid),
        .i_word          (word),
        .i_hold          (hold),
        .i_inst_valid    (inst_valid),
        .i_inst          (inst),
        .i_pc            (pc),
        .i_compressed    (compressed),
        .i_illegal       (illegal),
        .i_finish        (finish),
        .i_prog_len      (n_inst),
        .o_value_errors  (value_errors),
        .o_stream_errors (stream_errors),
        .o_checked       (checked),
        .o_done          (report_done)
    );

    // one compressed parcel of the chosen kind with random fields.
    function automatic logic [15:0] make_parcel(int sel, logic [31:0] r);
        logic [2:0] f3;
        f3 = r[15:13];
        case (sel)
            0: return {3'b000, r[12:2], 2'b01};
            1: return {3'b010, r[12:2], 2'b01};
            2: return {3'b011, r[12:2], 2'b01};
            3: return {3'b100, r[12], 2'b00, r[9:2], 2'b01};
            4: return {3'b100, r[12], 2'b01, r[9:2], 2'b01};
            5: return {3'b100, r[12], 2'b10, r[9:2], 2'b01};
            6: return {3'b100, r[12] & r[11], 2'b11, r[9:2], 2'b01};
            7: return {3'b000, r[12:2], 2'b10};
            8: return {3'b100, 1'b0, r[11:2], 2'b10};
            9: return {3'b100, 1'b1, r[11:2], 2'b10};
            // c.lui with rd x0 or x2.
            10: return {3'b011, r[12], 3'b000, r[0], 1'b0, r[6:2], 2'b01};
            11: return {3'b011, 1'b0, r[11:7], 5'b00000, 2'b01};
            12: return {r[15:2], 2'b00};
            13: return {r[14] ? 2'b11 : 2'b00, r[13] | !r[14], r[12:2], 2'b01};
            default:
            begin
                // quadrant 2 without slli and mv/add.
                if (f3 == 3'b000 || f3 == 3'b100)
                    f3[1] = 1'b1;
                return {f3, r[12:2], 2'b10};
            end
        endcase
    endfunction

    task automatic build_program();
        logic [31:0] r;
        int          sel;
        int          i;
        for (i = 0; i < PROG_LEN; i++)
        begin
            r   = $random(seed);
            sel = {$random(seed)} % 21;
            if (sel >= 15)
            begin
                parcels.push_back(r[15:0] | 16'h0003);
                parcels.push_back(r[31:16]);
            end
            else
                parcels.push_back(make_parcel(sel, r));
        end
        n_inst = PROG_LEN;
        // a c.nop fills an odd last word.
        if (parcels.size() % 2 != 0)
        begin
            parcels.push_back(16'h0001);
            n_inst = n_inst + 1;
        end
        for (i = 0; i < parcels.size(); i += 2)
            words.push_back({parcels[i + 1], parcels[i]});
    endtask

    task automatic show_counts();
        $display("checked %0d of %0d instructions, %0d value errors, %0d stream errors",
                 checked, n_inst, value_errors, stream_errors);
    endtask

    initial
    begin
        build_program();
        word_idx = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // a word stays on the bus until the aligner takes it.
        while (word_idx < words.size())
        begin
            if (word_valid && !hold)
                word_idx = word_idx + 1;
            if (word_idx < words.size() && ({$random(seed)} % 4 != 0))
            begin
                word_valid <= 1'b1;
                word       <= words[word_idx];
            end
            else
                word_valid <= 1'b0;
            @(posedge clk);
        end
        // the buffer drains within three cycles.
        repeat (4) @(posedge clk);
        finish <= 1'b1;
        wait (report_done);
        show_counts();
        if (value_errors + stream_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: the front end stopped taking words before the program ended");
        show_counts();
        $display("Simulation failed");
        $finish;
    end

endmodule

/* files.f */
+incdir+hw
hw/rv_isa_pkg.sv
hw/fetch_pkg.sv
hw/parcel_aligner.sv
hw/c_expander.sv
hw/fetch_frontend.sv
tb/tb_checker.sv
tb/tb_frontend.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f files.f --top-module tb_frontend \
    -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
